//--- slide_unit.f
+incdir+bench
src/slide_pkg.sv
src/slide_insn_queue.sv
src/slide_byte_mover.sv
src/slide_result_queue.sv
src/slide_unit.sv
bench/slide_unit_tb.sv

//--- Bender.yml
package:
  name: slide_unit

sources:
  - src/slide_pkg.sv
  - src/slide_insn_queue.sv
  - src/slide_byte_mover.sv
  - src/slide_result_queue.sv
  - src/slide_unit.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/slide_unit_tb.sv

//--- bench/slide_model.svh
/* Slide reference model
   Word counts and byte mapping of slide-up and slide-down, worked out
   per destination byte from the instruction rules */

`ifndef SLIDE_MODEL_SVH
`define SLIDE_MODEL_SVH

// Rounded-up division for word counts
function automatic int unsigned ceil_div(int unsigned a, int unsigned b);
  return (a + b - 1) / b;
endfunction

// Element count times element size in bytes
function automatic int unsigned scaled_bytes(int unsigned cnt, sew_e sew);
  return cnt * (1 << sew);
endfunction

// Source words read by one instruction
function automatic int unsigned src_word_cnt(slide_op_e op, int unsigned n,
                                             int unsigned s, int unsigned w);
  // Slide-down also reads the discarded head bytes
  if (op == OP_SLIDEUP) begin
    return ceil_div(n - s, w);
  end
  return ceil_div(n, w);
endfunction

// Result words written by one instruction
function automatic int unsigned res_word_cnt(slide_op_e op, int unsigned n,
                                             int unsigned s, int unsigned w);
  if (op == OP_SLIDEUP) begin
    return ceil_div(n, w);
  end
  return ceil_div(n - s, w);
endfunction

// Source byte landing on destination byte i, -1 when none does
function automatic int src_index(slide_op_e op, int n, int s, int i);
  if (op == OP_SLIDEUP) begin
    return (i >= s && i < n) ? i - s : -1;
  end
  return (i + s < n) ? i + s : -1;
endfunction

`endif

//--- bench/slide_unit_tb.sv
/* Slide unit testbench
   Table of slide instructions with LFSR source data and lane grants,
   checking every lane write and done pulse against the reference model */

`timescale 1ns/1ns
`default_nettype none

module slide_unit_tb import slide_pkg::*; ();

  localparam int unsigned NrLanes     = 4;
  localparam int unsigned WordBytes   = NrLanes * ElenBytes;
  localparam int unsigned WordsPerReg = VlenBytes / WordBytes;
  localparam int unsigned NumRows     = 9;
  // First row of the stall test, earlier rows run with free operands
  localparam int unsigned HoldRow     = 6;
  localparam int unsigned MaxWords    = 32;

  `include "slide_model.svh"

  logic                        clk, rst_n;
  slide_req_t                  req;
  logic                        req_valid, req_ready;
  elen_t         [NrLanes-1:0] operand;
  logic          [NrLanes-1:0] operand_valid;
  logic                        operand_ready;
  logic          [NrLanes-1:0] result_req;
  lane_payload_t [NrLanes-1:0] result;
  logic          [NrLanes-1:0] result_gnt;
  logic          [NrVInsn-1:0] done;

  // Instruction table
  slide_req_t    row_req  [NumRows];
  int unsigned   row_gnt  [NumRows];
  string         row_name [NumRows];
  // Result words up to and including each row
  int unsigned   row_end  [NumRows];

  // Source byte stream and expected lane writes, in issue order
  logic [7:0]    src_byte [MaxWords*WordBytes];
  lane_payload_t exp_word [MaxWords][NrLanes];
  int unsigned   exp_row  [MaxWords];
  int unsigned   src_total, res_total;

  int unsigned   op_idx, done_seen, writes, errors, cycles, cycle_limit;
  int unsigned   lane_ptr [NrLanes];
  logic          hold_operands;
  logic [31:0]   lfsr_q;

  slide_unit #(
    .NrLanes (NrLanes)
  ) i_slide_unit (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .req_i           (req),
    .req_valid_i     (req_valid),
    .req_ready_o     (req_ready),
    .operand_i       (operand),
    .operand_valid_i (operand_valid),
    .operand_ready_o (operand_ready),
    .result_req_o    (result_req),
    .result_o        (result),
    .result_gnt_i    (result_gnt),
    .done_o          (done)
  );

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] take_bits(int unsigned n);
    logic [31:0] v;
    v = '0;
    for (int unsigned i = 0; i < n; i++) begin
      v      = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1);
    end
    return v;
  endfunction

  task automatic set_row(input int unsigned idx, input string name, input vid_t id,
                         input slide_op_e op, input vreg_t vd, input vl_t vl,
                         input sew_e sew, input vl_t stride, input int unsigned pct);
    row_name[idx]       = name;
    row_req[idx].id     = id;
    row_req[idx].op     = op;
    row_req[idx].vd     = vd;
    row_req[idx].vl     = vl;
    row_req[idx].sew    = sew;
    row_req[idx].stride = stride;
    row_gnt[idx]        = pct;
  endtask

  task automatic load_table();
    // Row, name, id, op, vd, vl, sew, stride, grant percent
    set_row(0, "up_ew8",      3'd0, OP_SLIDEUP,   5'd2,  8'd40,  EW8,  8'd5,  100);
    set_row(1, "down_ew32",   3'd1, OP_SLIDEDOWN, 5'd5,  8'd20,  EW32, 8'd3,  100);
    set_row(2, "down_ew64",   3'd2, OP_SLIDEDOWN, 5'd9,  8'd16,  EW64, 8'd2,  60);
    set_row(3, "up_ew16",     3'd3, OP_SLIDEUP,   5'd12, 8'd30,  EW16, 8'd7,  40);
    set_row(4, "up_full",     3'd4, OP_SLIDEUP,   5'd20, 8'd128, EW8,  8'd31, 50);
    set_row(5, "down_short",  3'd5, OP_SLIDEDOWN, 5'd31, 8'd9,   EW8,  8'd4,  70);
    // Stall test rows
    set_row(6, "stall_up",    3'd6, OP_SLIDEUP,   5'd1,  8'd8,   EW32, 8'd1,  80);
    set_row(7, "stall_down",  3'd7, OP_SLIDEDOWN, 5'd3,  8'd12,  EW16, 8'd9,  30);
    set_row(8, "stall_third", 3'd0, OP_SLIDEUP,   5'd7,  8'd10,  EW64, 8'd3,  90);
  endtask

  // Source stream and expected words for the whole table
  task automatic build_expected();
    int unsigned n, s, ns, nr, base;
    int          j;
    src_total = 0;
    res_total = 0;
    for (int unsigned r = 0; r < NumRows; r++) begin
      n    = scaled_bytes(row_req[r].vl, row_req[r].sew);
      s    = scaled_bytes(row_req[r].stride, row_req[r].sew);
      ns   = src_word_cnt(row_req[r].op, n, s, WordBytes);
      nr   = res_word_cnt(row_req[r].op, n, s, WordBytes);
      base = src_total * WordBytes;
      for (int unsigned b = 0; b < ns * WordBytes; b++) begin
        src_byte[base + b] = 8'(take_bits(8));
      end
      for (int unsigned k = 0; k < nr; k++) begin
        for (int unsigned l = 0; l < NrLanes; l++) begin
          exp_word[res_total][l].id    = row_req[r].id;
          exp_word[res_total][l].addr  = vaddr_t'(row_req[r].vd * WordsPerReg + k);
          exp_word[res_total][l].wdata = '0;
          exp_word[res_total][l].be    = '0;
        end
        // Byte i of a word sits in lane i/8
        for (int unsigned i = 0; i < WordBytes; i++) begin
          j = src_index(row_req[r].op, n, s, int'(k * WordBytes + i));
          if (j >= 0) begin
            exp_word[res_total][i / ElenBytes].wdata[8*(i % ElenBytes) +: 8] =
              src_byte[base + j];
            exp_word[res_total][i / ElenBytes].be[i % ElenBytes] = 1'b1;
          end
        end
        exp_row[res_total] = r;
        res_total++;
      end
      row_end[r] = res_total;
      src_total += ns;
    end
  endtask

  task automatic drive_request(input int unsigned r);
    @(negedge clk);
    req       = row_req[r];
    req_valid = 1'b1;
  endtask

  // Returns right after the accepting edge
  task automatic wait_accept();
    do begin
      @(posedge clk);
    end while (!req_ready);
  endtask

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, %0d of %0d instructions done",
               cycles, done_seen, NumRows);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  // Lane models drive operands and random grants on the falling edge
  always @(negedge clk) begin
    int unsigned pct;
    if (hold_operands || op_idx >= src_total) begin
      operand_valid = '0;
    end else begin
      operand_valid = '1;
      for (int unsigned l = 0; l < NrLanes; l++) begin
        for (int unsigned b = 0; b < ElenBytes; b++) begin
          operand[l][8*b +: 8] = src_byte[op_idx*WordBytes + ElenBytes*l + b];
        end
      end
    end
    for (int unsigned l = 0; l < NrLanes; l++) begin
      result_gnt[l] = 1'b0;
      // Grant draws only for a pending request
      if (result_req[l] === 1'b1) begin
        pct = (lane_ptr[l] < res_total) ? row_gnt[exp_row[lane_ptr[l]]] : 0;
        result_gnt[l] = (take_bits(8) * 100 < pct * 256);
      end
    end
  end

  // Handshakes seen on the rising edge
  always @(posedge clk) begin
    lane_payload_t      want;
    logic [NrVInsn-1:0] done_want;
    if (rst_n) begin
      if (operand_ready) begin
        assert (op_idx < src_total) else begin
          errors++;
          $display("Operand consumed beyond the %0d source words of the table", src_total);
        end
        op_idx++;
      end
      // Done order and word count are checked before this edge's grants
      if (done != '0) begin
        if (done_seen < NumRows) begin
          done_want = '0;
          done_want[row_req[done_seen].id] = 1'b1;
          assert (done === done_want) else begin
            errors++;
            $display("FAILED %s done: expected %h, actual %h",
                     row_name[done_seen], done_want, done);
          end
          for (int unsigned l = 0; l < NrLanes; l++) begin
            assert (lane_ptr[l] == row_end[done_seen]) else begin
              errors++;
              $display("FAILED %s lane %0d words at done: expected %0d, actual %0d",
                       row_name[done_seen], l, row_end[done_seen], lane_ptr[l]);
            end
          end
        end else begin
          errors++;
          $display("Done pulse %h after every instruction had finished", done);
        end
        done_seen++;
      end
      for (int unsigned l = 0; l < NrLanes; l++) begin
        if (result_req[l] && result_gnt[l]) begin
          if (lane_ptr[l] < res_total) begin
            want = exp_word[lane_ptr[l]][l];
            assert (result[l] === want) else begin
              errors++;
              $display("FAILED %s lane %0d word %0d: expected %h, actual %h",
                       row_name[exp_row[lane_ptr[l]]], l, lane_ptr[l], want, result[l]);
            end
          end else begin
            errors++;
            $display("Lane %0d got more writes than the table produces", l);
          end
          lane_ptr[l]++;
          writes++;
        end
      end
    end
  end

  initial begin
    rst_n         = 1'b0;
    req           = '0;
    req_valid     = 1'b0;
    operand       = '0;
    operand_valid = '0;
    result_gnt    = '0;
    hold_operands = 1'b0;
    lfsr_q        = 32'hd9e4_7a54;
    op_idx        = 0;
    done_seen     = 0;
    writes        = 0;
    errors        = 0;
    cycles        = 0;
    for (int unsigned l = 0; l < NrLanes; l++) begin
      lane_ptr[l] = 0;
    end
    load_table();
    build_expected();
    cycle_limit = res_total * 20 + 100;

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Idle outputs after reset
    @(posedge clk);
    assert (req_ready === 1'b1 && result_req === '0 && done === '0 &&
            operand_ready === 1'b0) else begin
      errors++;
      $display("FAILED reset_idle: expected ready 1 req 0 done 0 operand ready 0, %s",
               $sformatf("actual ready %b req %b done %h operand ready %b",
                         req_ready, result_req, done, operand_ready));
    end

    for (int unsigned r = 0; r < HoldRow; r++) begin
      drive_request(r);
      wait_accept();
    end
    @(negedge clk);
    req_valid = 1'b0;
    while (done_seen < HoldRow) @(negedge clk);

    // Withheld operands keep two instructions in the queue
    @(posedge clk);
    hold_operands = 1'b1;
    drive_request(HoldRow);
    wait_accept();
    drive_request(HoldRow + 1);
    wait_accept();
    drive_request(HoldRow + 2);
    repeat (4) begin
      @(posedge clk);
      assert (req_ready === 1'b0) else begin
        errors++;
        $display("FAILED stall_ready req_ready: expected 0, actual %b", req_ready);
      end
    end
    hold_operands = 1'b0;
    wait_accept();
    @(negedge clk);
    req_valid = 1'b0;
    while (done_seen < NumRows) @(negedge clk);
    repeat (4) @(negedge clk);

    for (int unsigned l = 0; l < NrLanes; l++) begin
      assert (lane_ptr[l] == res_total) else begin
        errors++;
        $display("FAILED drain lane %0d writes: expected %0d, actual %0d",
                 l, res_total, lane_ptr[l]);
      end
    end
    assert (op_idx == src_total && result_req === '0) else begin
      errors++;
      $display("Unit not drained: %0d of %0d operands used, requests %b",
               op_idx, src_total, result_req);
    end

    $display("Lane writes %0d, done pulses %0d, errors %0d", writes, done_seen, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- src/slide_unit.sv
/* Vector slide unit
   Accepts slide-up and slide-down instructions, shifts lane operands by
   the byte offset and writes result words back to the lanes */

`timescale 1ns/1ns
`default_nettype none

module slide_unit import slide_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  // Sequencer requests
  input  slide_req_t                  req_i,
  input  logic                        req_valid_i,
  output logic                        req_ready_o,
  // Source operands from the lanes
  input  elen_t         [NrLanes-1:0] operand_i,
  input  logic          [NrLanes-1:0] operand_valid_i,
  output logic                        operand_ready_o,
  // Lane write ports
  output logic          [NrLanes-1:0] result_req_o,
  output lane_payload_t [NrLanes-1:0] result_o,
  input  logic          [NrLanes-1:0] result_gnt_i,
  // One pulse per finished instruction id
  output logic          [NrVInsn-1:0] done_o
);

  slide_req_t                  issue_req;
  logic                        issue_valid;
  logic                        issue_done;
  logic                        push;
  lane_payload_t [NrLanes-1:0] push_word;
  logic                        result_full;
  logic                        word_retired;

  slide_insn_queue #(
    .NrLanes (NrLanes),
    .Depth   (2)
  ) i_insn_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .req_valid_i    (req_valid_i),
    .req_ready_o    (req_ready_o),
    .issue_req_o    (issue_req),
    .issue_valid_o  (issue_valid),
    .issue_done_i   (issue_done),
    .word_retired_i (word_retired),
    .done_o         (done_o)
  );

  slide_byte_mover #(
    .NrLanes (NrLanes)
  ) i_byte_mover (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .issue_req_i     (issue_req),
    .issue_valid_i   (issue_valid),
    .issue_done_o    (issue_done),
    .operand_i       (operand_i),
    .operand_valid_i (operand_valid_i),
    .operand_ready_o (operand_ready_o),
    .result_full_i   (result_full),
    .push_o          (push),
    .push_word_o     (push_word)
  );

  slide_result_queue #(
    .NrLanes (NrLanes),
    .Depth   (2)
  ) i_result_queue (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .push_i         (push),
    .push_word_i    (push_word),
    .full_o         (result_full),
    .result_req_o   (result_req_o),
    .result_o       (result_o),
    .result_gnt_i   (result_gnt_i),
    .word_retired_o (word_retired)
  );

endmodule

`default_nettype wire

//--- src/slide_result_queue.sv
/* Slide result buffer
   Ring of result words with one valid bit per lane. Lanes are granted
   independently and an entry retires once every lane has taken its write */

`timescale 1ns/1ns
`default_nettype none

module slide_result_queue import slide_pkg::*; #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned Depth   = 2
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        push_i,
  input  lane_payload_t [NrLanes-1:0] push_word_i,
  output logic                        full_o,
  output logic          [NrLanes-1:0] result_req_o,
  output lane_payload_t [NrLanes-1:0] result_o,
  input  logic          [NrLanes-1:0] result_gnt_i,
  output logic                        word_retired_o
);

  localparam int unsigned PntWidth = (Depth > 1) ? $clog2(Depth) : 1;

  typedef logic [PntWidth-1:0] pnt_t;
  typedef logic [PntWidth:0]   cnt_t;

  lane_payload_t [Depth-1:0][NrLanes-1:0] entry_q;
  // Lanes still waiting to take each entry
  logic          [Depth-1:0][NrLanes-1:0] valid_d, valid_q;
  pnt_t                                   wr_pnt_q, rd_pnt_q;
  cnt_t                                   cnt_q;
  // Head lanes that remain unserved after this cycle's grants
  logic          [NrLanes-1:0]            pending;

  function automatic pnt_t bump(pnt_t p);
    return (p == pnt_t'(Depth - 1)) ? '0 : p + 1'b1;
  endfunction

  assign full_o = (cnt_q == cnt_t'(Depth));

  // Head entry drives the lane requests
  assign result_req_o = valid_q[rd_pnt_q];
  assign result_o     = entry_q[rd_pnt_q];

  assign pending        = valid_q[rd_pnt_q] & ~result_gnt_i;
  assign word_retired_o = (cnt_q != '0) && (pending == '0);

  always_comb begin
    valid_d           = valid_q;
    valid_d[rd_pnt_q] = pending;
    // New word asks every lane
    if (push_i) begin
      valid_d[wr_pnt_q] = '1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      entry_q[wr_pnt_q] <= push_word_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= '0;
      wr_pnt_q <= '0;
      rd_pnt_q <= '0;
      cnt_q    <= '0;
    end else begin
      valid_q <= valid_d;
      if (push_i) begin
        wr_pnt_q <= bump(wr_pnt_q);
      end
      if (word_retired_o) begin
        rd_pnt_q <= bump(rd_pnt_q);
      end
      cnt_q <= cnt_q + cnt_t'(push_i) - cnt_t'(word_retired_o);
    end
  end

  // Lanes only grant a pending request
  a_gnt_needs_req : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (result_gnt_i & ~result_req_o) == '0);

  // Pushes stop while every entry is taken
  a_no_push_when_full : assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> !full_o);

endmodule

`default_nettype wire

//--- src/slide_byte_mover.sv
/* Slide byte mover
   FSM that copies source bytes to their offset positions and assembles
   result words, pushing each finished word into the result buffer */

`timescale 1ns/1ns
`default_nettype none

module slide_byte_mover import slide_pkg::*; #(
  parameter int unsigned NrLanes = 4
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  slide_req_t                  issue_req_i,
  input  logic                        issue_valid_i,
  output logic                        issue_done_o,
  input  elen_t         [NrLanes-1:0] operand_i,
  input  logic          [NrLanes-1:0] operand_valid_i,
  output logic                        operand_ready_o,
  input  logic                        result_full_i,
  output logic                        push_o,
  output lane_payload_t [NrLanes-1:0] push_word_o
);

  localparam int unsigned WordBits    = NrLanes * $bits(elen_t);
  localparam byte_cnt_t   WordBytes   = byte_cnt_t'(NrLanes * ElenBytes);
  localparam int unsigned WordsPerReg = VlenBytes / (NrLanes * ElenBytes);

  typedef enum logic {
    SLIDE_IDLE,
    SLIDE_RUN
  } slide_state_e;

  slide_state_e state_d, state_q;

  // Byte pointers in the current source and result words
  byte_cnt_t in_pnt_d, in_pnt_q;
  byte_cnt_t out_pnt_d, out_pnt_q;
  // Bytes still to be copied for this instruction
  byte_cnt_t remain_d, remain_q;
  // Index of the result word being assembled
  vaddr_t    out_word_d, out_word_q;

  // Result word under assembly, flat over all lanes
  logic [WordBits-1:0]   data_d, data_q, data_asm;
  logic [WordBits/8-1:0] be_d, be_q, be_asm;
  logic [WordBits-1:0]   in_flat;

  byte_cnt_t vl_bytes, stride_bytes;
  byte_cnt_t in_span, out_span, step;
  logic      step_en, last;
  vaddr_t    base_addr;

  assign in_flat      = operand_i;
  assign vl_bytes     = to_bytes(issue_req_i.vl, issue_req_i.sew);
  assign stride_bytes = to_bytes(issue_req_i.stride, issue_req_i.sew);
  assign base_addr    = vaddr_t'(issue_req_i.vd * WordsPerReg);

  // Move only when every lane has its operand and the buffer has room
  assign step_en  = (state_q == SLIDE_RUN) && (&operand_valid_i) && !result_full_i;
  assign in_span  = WordBytes - in_pnt_q;
  assign out_span = WordBytes - out_pnt_q;
  // Smallest of source span, result span and remaining bytes
  assign step = (in_span < out_span) ? ((in_span < remain_q) ? in_span : remain_q) :
                                       ((out_span < remain_q) ? out_span : remain_q);
  assign last = (remain_q == step);

  // Byte copy into the assembly word
  always_comb begin
    data_asm = data_q;
    be_asm   = be_q;
    if (step_en) begin
      for (int unsigned b = 0; b < WordBytes; b++) begin
        if (b < step) begin
          data_asm[8*(out_pnt_q + b) +: 8] = in_flat[8*(in_pnt_q + b) +: 8];
          be_asm[out_pnt_q + b]            = 1'b1;
        end
      end
    end
  end

  always_comb begin
    state_d         = state_q;
    in_pnt_d        = in_pnt_q;
    out_pnt_d       = out_pnt_q;
    remain_d        = remain_q;
    out_word_d      = out_word_q;
    data_d          = data_asm;
    be_d            = be_asm;
    issue_done_o    = 1'b0;
    operand_ready_o = 1'b0;
    push_o          = 1'b0;

    unique case (state_q)
      SLIDE_IDLE: begin
        if (issue_valid_i) begin
          state_d    = SLIDE_RUN;
          out_word_d = '0;
          data_d     = '0;
          be_d       = '0;
          remain_d   = vl_bytes - stride_bytes;
          // Slide-up writes at the offset, slide-down reads from it
          if (issue_req_i.op == OP_SLIDEUP) begin
            in_pnt_d  = '0;
            out_pnt_d = stride_bytes;
          end else begin
            in_pnt_d  = stride_bytes;
            out_pnt_d = '0;
          end
        end
      end
      SLIDE_RUN: begin
        if (step_en) begin
          in_pnt_d  = in_pnt_q + step;
          out_pnt_d = out_pnt_q + step;
          remain_d  = remain_q - step;
          // Source word used up
          if (in_pnt_d == WordBytes || last) begin
            in_pnt_d        = '0;
            operand_ready_o = 1'b1;
          end
          // Result word full, or tail of the instruction
          if (out_pnt_d == WordBytes || last) begin
            out_pnt_d  = '0;
            push_o     = 1'b1;
            out_word_d = out_word_q + 1'b1;
            data_d     = '0;
            be_d       = '0;
          end
          if (last) begin
            state_d      = SLIDE_IDLE;
            issue_done_o = 1'b1;
          end
        end
      end
      default: state_d = SLIDE_IDLE;
    endcase
  end

  // Pushed word carries this cycle's bytes
  always_comb begin
    for (int unsigned l = 0; l < NrLanes; l++) begin
      push_word_o[l].id    = issue_req_i.id;
      push_word_o[l].addr  = base_addr + out_word_q;
      push_word_o[l].wdata = data_asm[64*l +: 64];
      push_word_o[l].be    = be_asm[8*l +: 8];
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= SLIDE_IDLE;
      in_pnt_q   <= '0;
      out_pnt_q  <= '0;
      remain_q   <= '0;
      out_word_q <= '0;
    end else begin
      state_q    <= state_d;
      in_pnt_q   <= in_pnt_d;
      out_pnt_q  <= out_pnt_d;
      remain_q   <= remain_d;
      out_word_q <= out_word_d;
    end
  end

  always_ff @(posedge clk_i) begin
    data_q <= data_d;
    be_q   <= be_d;
  end

  // Offset below the vector length leaves bytes to copy while running
  a_remain_nonzero : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == SLIDE_RUN) |-> (remain_q != '0));

endmodule

`default_nettype wire

//--- src/slide_insn_queue.sv
/* Slide instruction queue
   Ring of accepted slide instructions with accept, issue and commit phases.
   Counts retired result words of the committing instruction and pulses its done bit */

`timescale 1ns/1ns
`default_nettype none

module slide_insn_queue import slide_pkg::*; #(
  parameter int unsigned NrLanes = 4,
  parameter int unsigned Depth   = 2
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  input  slide_req_t         req_i,
  input  logic               req_valid_i,
  output logic               req_ready_o,
  output slide_req_t         issue_req_o,
  output logic               issue_valid_o,
  input  logic               issue_done_i,
  input  logic               word_retired_i,
  output logic [NrVInsn-1:0] done_o
);

  localparam int unsigned PntWidth  = (Depth > 1) ? $clog2(Depth) : 1;
  // Bytes in one result word across all lanes
  localparam byte_cnt_t   WordBytes = byte_cnt_t'(NrLanes * ElenBytes);

  typedef logic [PntWidth-1:0] pnt_t;
  typedef logic [PntWidth:0]   cnt_t;

  slide_req_t [Depth-1:0] insn_q;
  pnt_t                   accept_pnt_q, issue_pnt_q, commit_pnt_q;
  // Instructions waiting for issue, and waiting for commit
  cnt_t                   issue_cnt_q, commit_cnt_q;
  // Result words already retired for the committing instruction
  byte_cnt_t              word_cnt_q;
  logic [NrVInsn-1:0]     done_q;

  logic       accept, commit;
  slide_req_t commit_req;
  byte_cnt_t  commit_bytes, commit_span, commit_words;
  byte_cnt_t  req_vl_bytes, req_stride_bytes;

  // Ring pointer increment with wrap at Depth
  function automatic pnt_t bump(pnt_t p);
    return (p == pnt_t'(Depth - 1)) ? '0 : p + 1'b1;
  endfunction

  // Ready while fewer than Depth instructions are held
  assign req_ready_o = (commit_cnt_q != cnt_t'(Depth));
  assign accept      = req_valid_i && req_ready_o;

  assign issue_req_o   = insn_q[issue_pnt_q];
  assign issue_valid_o = (issue_cnt_q != '0);

  // Result words of the committing instruction
  // Slide-up writes ceil(N/W), slide-down ceil((N-S)/W)
  assign commit_req   = insn_q[commit_pnt_q];
  assign commit_bytes = to_bytes(commit_req.vl, commit_req.sew);
  assign commit_span  = (commit_req.op == OP_SLIDEUP) ? commit_bytes :
                        commit_bytes - to_bytes(commit_req.stride, commit_req.sew);
  assign commit_words = (commit_span + WordBytes - 1'b1) / WordBytes;

  assign commit = (commit_cnt_q != '0) && word_retired_i &&
                  (word_cnt_q + 1 == commit_words);

  assign done_o = done_q;

  // Instruction storage
  always_ff @(posedge clk_i) begin
    if (accept) begin
      insn_q[accept_pnt_q] <= req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      accept_pnt_q <= '0;
      issue_pnt_q  <= '0;
      commit_pnt_q <= '0;
      issue_cnt_q  <= '0;
      commit_cnt_q <= '0;
      word_cnt_q   <= '0;
      done_q       <= '0;
    end else begin
      // Done bits are single-cycle pulses
      done_q <= '0;
      if (commit) begin
        done_q[commit_req.id] <= 1'b1;
      end
      if (word_retired_i) begin
        word_cnt_q <= commit ? '0 : word_cnt_q + 1'b1;
      end
      if (accept) begin
        accept_pnt_q <= bump(accept_pnt_q);
      end
      if (issue_done_i) begin
        issue_pnt_q <= bump(issue_pnt_q);
      end
      if (commit) begin
        commit_pnt_q <= bump(commit_pnt_q);
      end
      issue_cnt_q  <= issue_cnt_q + cnt_t'(accept) - cnt_t'(issue_done_i);
      commit_cnt_q <= commit_cnt_q + cnt_t'(accept) - cnt_t'(commit);
    end
  end

  // Byte offset stays inside one word and inside the vector
  assign req_vl_bytes     = to_bytes(req_i.vl, req_i.sew);
  assign req_stride_bytes = to_bytes(req_i.stride, req_i.sew);

  a_stride_in_range : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept |-> (req_stride_bytes < WordBytes) && (req_stride_bytes < req_vl_bytes));

endmodule

`default_nettype wire

//--- src/slide_pkg.sv
/* Slide unit package
   Shared lane widths, instruction and lane-write types and sizing constants
   used by every block of the vector slide unit */

`default_nettype none

package slide_pkg;

  // Bytes held by one lane word
  localparam int unsigned ElenBytes = 8;
  // Number of distinct instruction ids in flight
  localparam int unsigned NrVInsn   = 8;
  // Bytes per vector register, summed over all lanes
  localparam int unsigned VlenBytes = 128;

  typedef logic [8*ElenBytes-1:0]      elen_t;
  typedef logic [ElenBytes-1:0]        strb_t;
  typedef logic [$clog2(NrVInsn)-1:0]  vid_t;
  typedef logic [4:0]                  vreg_t;
  // Vector length and stride, in elements
  typedef logic [7:0]                  vl_t;
  // Byte counts and byte pointers inside a vector
  typedef logic [7:0]                  byte_cnt_t;
  typedef logic [8:0]                  vaddr_t;

  typedef enum logic [1:0] {
    EW8,
    EW16,
    EW32,
    EW64
  } sew_e;

  typedef enum logic {
    OP_SLIDEUP,
    OP_SLIDEDOWN
  } slide_op_e;

  // One slide instruction as issued by the sequencer
  typedef struct packed {
    vid_t      id;
    slide_op_e op;
    vreg_t     vd;
    vl_t       vl;
    sew_e      sew;
    vl_t       stride;
  } slide_req_t;

  // Write request towards one lane
  typedef struct packed {
    vid_t   id;
    vaddr_t addr;
    elen_t  wdata;
    strb_t  be;
  } lane_payload_t;

  // Element count scaled to bytes by the element width code
  function automatic byte_cnt_t to_bytes(vl_t n, sew_e sew);
    return byte_cnt_t'(n << sew);
  endfunction

endpackage

`default_nettype wire
